//--- hw/isa_pkg.sv
package isa_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    // primary opcode, instr[31:26]
    typedef enum logic [OP_W-1:0] {
        R_TYPE = 6'h00,
        ADDI   = 6'h08,
        SLTI   = 6'h0a,
        ANDI   = 6'h0c,
        ORI    = 6'h0d,
        XORI   = 6'h0e,
        LUI    = 6'h0f,
        LB     = 6'h20,
        LH     = 6'h21,
        LW     = 6'h23,
        LBU    = 6'h24,
        LHU    = 6'h25,
        SB     = 6'h28,
        SH     = 6'h29,
        SW     = 6'h2b
    } opcode_e;

    // R-type funct field, also fed straight to the alu
    typedef enum logic [OP_W-1:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2a
    } funct_e;

    // where the execute stage takes its alu operation from
    typedef enum logic [1:0] {
        MEM_ADDR   = 2'd0,
        NO_ALU     = 2'd1,
        USE_FUNCT  = 2'd2,
        USE_OPCODE = 2'd3
    } alu_class_e;

endpackage

//--- hw/pipe_pkg.sv
package pipe_pkg;

    // access size for loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_width_e;

    // operand source in the execute stage
    typedef enum logic [1:0] {
        FROM_REG = 2'd0,
        FROM_WB  = 2'd1,
        FROM_MEM = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        logic                reg_dest;
        logic                alu_src;
        isa_pkg::alu_class_e alu_class;
    } ex_ctl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        logic       load_unsigned;
        mem_width_e width;
    } mem_ctl_t;

    typedef struct packed {
        logic mem_to_reg;
        logic reg_write;
    } wb_ctl_t;

    typedef struct packed {
        ex_ctl_t                         ex_ctl;
        mem_ctl_t                        mem_ctl;
        wb_ctl_t                         wb_ctl;
        logic [isa_pkg::DATA_W-1:0]      ra;
        logic [isa_pkg::DATA_W-1:0]      rb;
        logic [isa_pkg::REG_ADDR_W-1:0]  rs;
        logic [isa_pkg::REG_ADDR_W-1:0]  rt;
        logic [isa_pkg::REG_ADDR_W-1:0]  rd;
        logic [isa_pkg::OP_W-1:0]        funct;
        logic [isa_pkg::OP_W-1:0]        opcode;
        logic [isa_pkg::SHAMT_W-1:0]     shamt;
        logic [isa_pkg::DATA_W-1:0]      imm;
    } id_ex_t;

    typedef struct packed {
        mem_ctl_t                        mem_ctl;
        wb_ctl_t                         wb_ctl;
        logic [isa_pkg::DATA_W-1:0]      alu_result;
        logic [isa_pkg::DATA_W-1:0]      store_data;
        logic [isa_pkg::REG_ADDR_W-1:0]  reg_dest;
    } ex_mem_t;

endpackage

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic signed [isa_pkg::DATA_W-1:0]  i_operand1,
    input  logic signed [isa_pkg::DATA_W-1:0]  i_operand2,
    input  logic        [isa_pkg::OP_W-1:0]    i_opcode,
    input  logic        [isa_pkg::SHAMT_W-1:0] i_shamt,
    output logic        [isa_pkg::DATA_W-1:0]  o_result
);

    import isa_pkg::*;

    // funct codes and I-type opcodes share one code space
    always_comb begin
        case (i_opcode)
            ADDU, ADDI: begin
                o_result = i_operand1 + i_operand2;
            end
            SUBU: begin
                o_result = i_operand1 - i_operand2;
            end
            AND, ANDI: begin
                o_result = i_operand1 & i_operand2;
            end
            OR, ORI: begin
                o_result = i_operand1 | i_operand2;
            end
            XOR, XORI: begin
                o_result = i_operand1 ^ i_operand2;
            end
            NOR: begin
                o_result = ~(i_operand1 | i_operand2);
            end
            SLT, SLTI: begin
                // both operands signed
                o_result = (i_operand1 < i_operand2) ? DATA_W'(1) : '0;
            end
            SLL: begin
                o_result = i_operand2 << i_shamt;
            end
            SRL: begin
                o_result = i_operand2 >> i_shamt;
            end
            SRA: begin
                o_result = i_operand2 >>> i_shamt;
            end
            LUI: begin
                o_result = i_operand2 << 16;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

//--- hw/forward_unit.sv
`timescale 1ns/1ps

module forward_unit (
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_rs,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_rt,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_mem_reg,
    input  logic                           i_mem_write_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_wb_reg,
    input  logic                           i_wb_write_en,
    output pipe_pkg::fwd_sel_e             o_fwd_a,
    output pipe_pkg::fwd_sel_e             o_fwd_b
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // youngest producer wins, r0 never forwards
    function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] src);
        if (src != '0 && i_mem_write_en && i_mem_reg == src) begin
            return FROM_MEM;
        end else if (src != '0 && i_wb_write_en && i_wb_reg == src) begin
            return FROM_WB;
        end
        return FROM_REG;
    endfunction

    always_comb begin
        o_fwd_a = pick(i_rs);
        o_fwd_b = pick(i_rt);
    end

endmodule

//--- hw/instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_halt,
    input  logic [isa_pkg::DATA_W-1:0]     i_instr,
    input  logic                           i_wb_write,
    input  logic [isa_pkg::REG_ADDR_W-1:0] i_wb_reg,
    input  logic [isa_pkg::DATA_W-1:0]     i_wb_data,
    output pipe_pkg::id_ex_t               o_id_ex
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0]     regs [NUM_REGS];
    logic [OP_W-1:0]       opcode;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [SHAMT_W-1:0]    shamt;
    logic [OP_W-1:0]       funct;
    logic [IMM_W-1:0]      imm16;
    logic                  imm_zero_ext;
    ex_ctl_t               ex_ctl;
    mem_ctl_t              mem_ctl;
    wb_ctl_t               wb_ctl;
    id_ex_t                id_ex_d;

    assign opcode = i_instr[31:26];
    assign rs     = i_instr[25:21];
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];
    assign shamt  = i_instr[10:6];
    assign funct  = i_instr[5:0];
    assign imm16  = i_instr[15:0];

    // r0 reads zero, a same-cycle write-back is bypassed
    function automatic logic [DATA_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wb_write && i_wb_reg == addr) begin
            return i_wb_data;
        end
        return regs[addr];
    endfunction

    function automatic mem_width_e width_of(input logic [OP_W-1:0] op);
        if (op == LB || op == LBU || op == SB) begin
            return BYTE;
        end else if (op == LH || op == LHU || op == SH) begin
            return HALF;
        end
        return WORD;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (!i_halt && i_wb_write && i_wb_reg != '0) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    // control decoder
    always_comb begin
        ex_ctl       = '0;
        mem_ctl      = '0;
        wb_ctl       = '0;
        imm_zero_ext = 1'b0;
        case (opcode)
            R_TYPE: begin
                ex_ctl.reg_dest  = 1'b1;
                ex_ctl.alu_class = USE_FUNCT;
                wb_ctl.reg_write = 1'b1;
            end
            ADDI, SLTI, LUI, ANDI, ORI, XORI: begin
                ex_ctl.alu_src   = 1'b1;
                ex_ctl.alu_class = USE_OPCODE;
                wb_ctl.reg_write = 1'b1;
                // logical immediates are zero extended
                imm_zero_ext     = (opcode == ANDI) || (opcode == ORI) || (opcode == XORI);
            end
            LB, LH, LW, LBU, LHU: begin
                ex_ctl.alu_src        = 1'b1;
                ex_ctl.alu_class      = MEM_ADDR;
                mem_ctl.mem_read      = 1'b1;
                mem_ctl.load_unsigned = (opcode == LBU) || (opcode == LHU);
                mem_ctl.width         = width_of(opcode);
                wb_ctl.mem_to_reg     = 1'b1;
                wb_ctl.reg_write      = 1'b1;
            end
            SB, SH, SW: begin
                ex_ctl.alu_src    = 1'b1;
                ex_ctl.alu_class  = MEM_ADDR;
                mem_ctl.mem_write = 1'b1;
                mem_ctl.width     = width_of(opcode);
            end
            default: begin
                ex_ctl.alu_class = NO_ALU;
            end
        endcase
    end

    always_comb begin
        id_ex_d.ex_ctl  = ex_ctl;
        id_ex_d.mem_ctl = mem_ctl;
        id_ex_d.wb_ctl  = wb_ctl;
        id_ex_d.ra      = read_reg(rs);
        id_ex_d.rb      = read_reg(rt);
        id_ex_d.rs      = rs;
        id_ex_d.rt      = rt;
        id_ex_d.rd      = rd;
        id_ex_d.funct   = funct;
        id_ex_d.opcode  = opcode;
        id_ex_d.shamt   = shamt;
        if (imm_zero_ext) begin
            id_ex_d.imm = {{(DATA_W - IMM_W){1'b0}}, imm16};
        end else begin
            id_ex_d.imm = {{(DATA_W - IMM_W){imm16[IMM_W-1]}}, imm16};
        end
    end

    // ID/EX register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_id_ex <= '0;
        end else if (!i_halt) begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule

//--- hw/instruction_exec.sv
`timescale 1ns/1ps

module instruction_exec (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_halt,
    input  pipe_pkg::id_ex_t           i_id_ex,
    input  pipe_pkg::fwd_sel_e         i_fwd_a,
    input  pipe_pkg::fwd_sel_e         i_fwd_b,
    input  logic [isa_pkg::DATA_W-1:0] i_mem_alu_result,
    input  logic [isa_pkg::DATA_W-1:0] i_wb_data,
    output pipe_pkg::ex_mem_t          o_ex_mem
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // no alu code, gives zero
    localparam logic [OP_W-1:0] ALU_IDLE = 6'h3f;

    logic signed [DATA_W-1:0] operand_a;
    logic signed [DATA_W-1:0] fwd_b;
    logic signed [DATA_W-1:0] operand_b;
    logic        [DATA_W-1:0] alu_result;
    logic        [OP_W-1:0]   alu_op;
    ex_mem_t                  ex_mem_d;

    alu u_alu (
        .i_operand1 (operand_a),
        .i_operand2 (operand_b),
        .i_opcode   (alu_op),
        .i_shamt    (i_id_ex.shamt),
        .o_result   (alu_result)
    );

    // alu control
    always_comb begin
        case (i_id_ex.ex_ctl.alu_class)
            MEM_ADDR:   alu_op = ADDU;
            USE_FUNCT:  alu_op = i_id_ex.funct;
            USE_OPCODE: alu_op = i_id_ex.opcode;
            default:    alu_op = ALU_IDLE;
        endcase
    end

    // forwarding muxes
    always_comb begin
        case (i_fwd_a)
            FROM_REG: operand_a = i_id_ex.ra;
            FROM_WB:  operand_a = i_wb_data;
            FROM_MEM: operand_a = i_mem_alu_result;
            default:  operand_a = '0;
        endcase
        case (i_fwd_b)
            FROM_REG: fwd_b = i_id_ex.rb;
            FROM_WB:  fwd_b = i_wb_data;
            FROM_MEM: fwd_b = i_mem_alu_result;
            default:  fwd_b = '0;
        endcase
    end

    // immediate replaces rt after forwarding
    assign operand_b = i_id_ex.ex_ctl.alu_src ? i_id_ex.imm : fwd_b;

    always_comb begin
        ex_mem_d.mem_ctl    = i_id_ex.mem_ctl;
        ex_mem_d.wb_ctl     = i_id_ex.wb_ctl;
        ex_mem_d.alu_result = alu_result;
        // stores write the forwarded rt value
        ex_mem_d.store_data = fwd_b;
        ex_mem_d.reg_dest   = i_id_ex.ex_ctl.reg_dest ? i_id_ex.rd : i_id_ex.rt;
    end

    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_mem <= '0;
        end else if (!i_halt) begin
            o_ex_mem <= ex_mem_d;
        end
    end

endmodule

//--- hw/mem_writeback.sv
`timescale 1ns/1ps

module mem_writeback #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_halt,
    input  pipe_pkg::ex_mem_t              i_ex_mem,
    output logic                           o_wb_write,
    output logic [isa_pkg::REG_ADDR_W-1:0] o_wb_reg,
    output logic [isa_pkg::DATA_W-1:0]     o_wb_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);
    localparam int LANES = DATA_W / 8;

    logic [DATA_W-1:0]     dmem [DMEM_WORDS];
    logic [IDX_W-1:0]      word_idx;
    logic [1:0]            byte_off;
    logic [LANES-1:0]      lane_en;
    logic [DATA_W-1:0]     lane_data;
    logic [DATA_W-1:0]     rd_word;
    logic [7:0]            rd_byte;
    logic [15:0]           rd_half;
    logic [DATA_W-1:0]     load_data;
    wb_ctl_t               wb_ctl_q;
    logic [DATA_W-1:0]     load_q;
    logic [DATA_W-1:0]     alu_q;
    logic [REG_ADDR_W-1:0] dest_q;

    // word addressed, low two bits pick the lane
    assign word_idx = i_ex_mem.alu_result[2 +: IDX_W];
    assign byte_off = i_ex_mem.alu_result[1:0];

    // store lane enables and replicated data
    always_comb begin
        case (i_ex_mem.mem_ctl.width)
            BYTE: begin
                lane_en   = 4'b0001 << byte_off;
                lane_data = {LANES{i_ex_mem.store_data[7:0]}};
            end
            HALF: begin
                lane_en   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_ex_mem.store_data[15:0]}};
            end
            default: begin
                lane_en   = '1;
                lane_data = i_ex_mem.store_data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (!i_halt && i_ex_mem.mem_ctl.mem_write) begin
            for (int b = 0; b < LANES; b++) begin
                if (lane_en[b]) begin
                    dmem[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    assign rd_word = dmem[word_idx];
    assign rd_byte = rd_word[8*byte_off +: 8];
    assign rd_half = rd_word[16*byte_off[1] +: 16];

    // load extension
    always_comb begin
        case (i_ex_mem.mem_ctl.width)
            BYTE: begin
                load_data = i_ex_mem.mem_ctl.load_unsigned ? {24'b0, rd_byte}
                                                           : {{24{rd_byte[7]}}, rd_byte};
            end
            HALF: begin
                load_data = i_ex_mem.mem_ctl.load_unsigned ? {16'b0, rd_half}
                                                           : {{16{rd_half[15]}}, rd_half};
            end
            default: begin
                load_data = rd_word;
            end
        endcase
    end

    // MEM/WB register
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wb_ctl_q <= '0;
            load_q   <= '0;
            alu_q    <= '0;
            dest_q   <= '0;
        end else if (!i_halt) begin
            wb_ctl_q <= i_ex_mem.wb_ctl;
            load_q   <= load_data;
            alu_q    <= i_ex_mem.alu_result;
            dest_q   <= i_ex_mem.reg_dest;
        end
    end

    // writes to r0 are dropped here
    assign o_wb_write = wb_ctl_q.reg_write && (dest_q != '0);
    assign o_wb_reg   = dest_q;
    assign o_wb_data  = wb_ctl_q.mem_to_reg ? load_q : alu_q;

endmodule

//--- hw/exec_pipeline.sv
`timescale 1ns/1ps

module exec_pipeline #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic                           i_halt,
    input  logic [isa_pkg::DATA_W-1:0]     i_instr,
    output logic                           o_wb_valid,
    output logic [isa_pkg::REG_ADDR_W-1:0] o_wb_reg,
    output logic [isa_pkg::DATA_W-1:0]     o_wb_data
);

    import pipe_pkg::*;

    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    instruction_decode u_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_instr    (i_instr),
        .i_wb_write (o_wb_valid),
        .i_wb_reg   (o_wb_reg),
        .i_wb_data  (o_wb_data),
        .o_id_ex    (id_ex)
    );

    forward_unit u_forward (
        .i_rs           (id_ex.rs),
        .i_rt           (id_ex.rt),
        .i_mem_reg      (ex_mem.reg_dest),
        .i_mem_write_en (ex_mem.wb_ctl.reg_write),
        .i_wb_reg       (o_wb_reg),
        .i_wb_write_en  (o_wb_valid),
        .o_fwd_a        (fwd_a),
        .o_fwd_b        (fwd_b)
    );

    instruction_exec u_exec (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_halt           (i_halt),
        .i_id_ex          (id_ex),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_mem_alu_result (ex_mem.alu_result),
        .i_wb_data        (o_wb_data),
        .o_ex_mem         (ex_mem)
    );

    mem_writeback #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_mem_wb (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_ex_mem   (ex_mem),
        .o_wb_write (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data)
    );

endmodule

//--- bench/exec_pipeline_sva.sv
`timescale 1ns/1ps

module exec_pipeline_sva (
    input logic               i_clk,
    input logic               i_reset,
    input logic               i_halt,
    input pipe_pkg::ex_mem_t  i_ex_mem
);

    import pipe_pkg::*;

    // EX/MEM controls come out of reset cleared
    a_reset_clears: assert property (@(posedge i_clk)
        i_reset |=> (i_ex_mem.mem_ctl == '0 && i_ex_mem.wb_ctl == '0))
        else $error("EX/MEM controls not cleared after reset");

    a_halt_holds: assert property (@(posedge i_clk) disable iff (i_reset)
        i_halt |=> $stable(i_ex_mem))
        else $error("EX/MEM register changed while halted");

    // a memory access is either a load or a store
    a_read_write_exclusive: assert property (@(posedge i_clk)
        !(i_ex_mem.mem_ctl.mem_read && i_ex_mem.mem_ctl.mem_write))
        else $error("mem_read and mem_write set together");

endmodule

bind instruction_exec exec_pipeline_sva u_sva (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_halt   (i_halt),
    .i_ex_mem (o_ex_mem)
);

//--- bench/exec_pipeline_tb.sv
`timescale 1ns/1ps

module exec_pipeline_tb;

    import isa_pkg::*;

    localparam int DMEM_WORDS = 64;
    localparam int MEM_BYTES  = 4 * DMEM_WORDS;
    // instructions per test, drain NOPs included
    localparam int INSTR_COUNT = 10 + 16 + 17 + 25 + 13 + 54;
    localparam int CYCLE_LIMIT = 4 * INSTR_COUNT + 200;

    logic        i_clk;
    logic        i_reset;
    logic        i_halt;
    logic [31:0] i_instr;
    logic        o_wb_valid;
    logic [4:0]  o_wb_reg;
    logic [31:0] o_wb_data;

    logic [31:0] model_regs [32];
    logic [7:0]  mem_model [MEM_BYTES];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_data [$];
    logic [4:0]  want_reg;
    logic [31:0] want_data;
    logic        prev_halt;
    logic        prev_valid;
    logic [4:0]  prev_reg;
    logic [31:0] prev_data;
    int          errors;
    int          checks;
    int          tests_run;
    int          err_at_start;
    int          cycle_count;
    integer      seed;

    exec_pipeline #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_halt     (i_halt),
        .i_instr    (i_instr),
        .o_wb_valid (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    // operand order as in assembly, rt first
    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // sequential reference, one instruction at a time
    task automatic apply_model(input logic [31:0] instr);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] val;
        logic        writes;
        int          ba;
        int          hb;
        int          wb;
        op     = instr[31:26];
        rs     = instr[25:21];
        rt     = instr[20:16];
        rd     = instr[15:11];
        shamt  = instr[10:6];
        fn     = instr[5:0];
        a      = model_regs[rs];
        b      = model_regs[rt];
        sx     = {{16{instr[15]}}, instr[15:0]};
        zx     = {16'h0000, instr[15:0]};
        ba     = (a + sx) % MEM_BYTES;
        hb     = ba & ~1;
        wb     = ba & ~3;
        writes = 1'b1;
        dest   = rt;
        val    = '0;
        case (op)
            R_TYPE: begin
                dest = rd;
                case (fn)
                    ADDU:    val = a + b;
                    SUBU:    val = a - b;
                    AND:     val = a & b;
                    OR:      val = a | b;
                    XOR:     val = a ^ b;
                    NOR:     val = ~(a | b);
                    SLT:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    SLL:     val = b << shamt;
                    SRL:     val = b >> shamt;
                    SRA:     val = $signed(b) >>> shamt;
                    default: val = '0;
                endcase
            end
            ADDI: val = a + sx;
            SLTI: val = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            ANDI: val = a & zx;
            ORI:  val = a | zx;
            XORI: val = a ^ zx;
            LUI:  val = {instr[15:0], 16'h0000};
            LW:   val = {mem_model[wb+3], mem_model[wb+2], mem_model[wb+1], mem_model[wb]};
            LH:   val = {{16{mem_model[hb+1][7]}}, mem_model[hb+1], mem_model[hb]};
            LHU:  val = {16'h0000, mem_model[hb+1], mem_model[hb]};
            LB:   val = {{24{mem_model[ba][7]}}, mem_model[ba]};
            LBU:  val = {24'h000000, mem_model[ba]};
            SB: begin
                writes        = 1'b0;
                mem_model[ba] = b[7:0];
            end
            SH: begin
                writes          = 1'b0;
                mem_model[hb]   = b[7:0];
                mem_model[hb+1] = b[15:8];
            end
            SW: begin
                writes = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    mem_model[wb+i] = b[8*i +: 8];
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes && dest != 5'd0) begin
            model_regs[dest] = val;
            exp_reg.push_back(dest);
            exp_data.push_back(val);
        end
    endtask

    task automatic issue(input logic [31:0] instr);
        @(negedge i_clk);
        i_halt  = 1'b0;
        i_instr = instr;
        apply_model(instr);
    endtask

    // four NOPs cover the 3-edge write-back latency
    task automatic drain();
        repeat (4) begin
            issue(32'h0000_0000);
        end
    endtask

    // junk instruction while halted must never show up
    task automatic hold_pipeline(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            i_halt  = 1'b1;
            i_instr = itype_word(ADDI, 5'd5, 5'd0, 16'h7777);
        end
    endtask

    task automatic start_test();
        err_at_start = errors;
    endtask

    task automatic end_test(input string name);
        assert (exp_reg.size() == 0) else begin
            $display("test %s: %0d expected write-backs never arrived", name, exp_reg.size());
            errors++;
            exp_reg.delete();
            exp_data.delete();
        end
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - err_at_start);
    endtask

    task automatic nop_test();
        start_test();
        repeat (6) begin
            issue(32'h0000_0000);
        end
        drain();
        end_test("nop");
    endtask

    task automatic dependency_test();
        start_test();
        issue(itype_word(ADDI, 5'd1, 5'd0, 16'd5));
        issue(itype_word(ADDI, 5'd2, 5'd0, 16'hfffd));
        issue(rtype_word(ADDU, 5'd3, 5'd1, 5'd2, 5'd0));
        issue(rtype_word(SUBU, 5'd4, 5'd3, 5'd1, 5'd0));
        issue(rtype_word(OR, 5'd5, 5'd4, 5'd3, 5'd0));
        issue(rtype_word(XOR, 5'd6, 5'd5, 5'd4, 5'd0));
        issue(rtype_word(AND, 5'd7, 5'd6, 5'd3, 5'd0));
        issue(rtype_word(NOR, 5'd8, 5'd7, 5'd5, 5'd0));
        issue(rtype_word(ADDU, 5'd8, 5'd8, 5'd8, 5'd0));
        issue(rtype_word(SUBU, 5'd9, 5'd0, 5'd8, 5'd0));
        // r0 result must neither land nor forward
        issue(rtype_word(ADDU, 5'd0, 5'd1, 5'd1, 5'd0));
        issue(rtype_word(ADDU, 5'd10, 5'd0, 5'd1, 5'd0));
        drain();
        end_test("dependency");
    endtask

    task automatic immediate_test();
        start_test();
        issue(itype_word(ADDI, 5'd11, 5'd0, 16'h8000));
        issue(itype_word(ANDI, 5'd12, 5'd11, 16'hffff));
        issue(itype_word(ORI, 5'd13, 5'd0, 16'h8001));
        issue(itype_word(XORI, 5'd14, 5'd11, 16'hf0f0));
        issue(itype_word(LUI, 5'd15, 5'd0, 16'hdead));
        issue(itype_word(ORI, 5'd15, 5'd15, 16'hbeef));
        issue(itype_word(SLTI, 5'd16, 5'd11, 16'hffff));
        issue(itype_word(SLTI, 5'd17, 5'd1, 16'hfff9));
        issue(rtype_word(SLT, 5'd18, 5'd11, 5'd1, 5'd0));
        issue(rtype_word(SLT, 5'd19, 5'd1, 5'd11, 5'd0));
        issue(rtype_word(SRA, 5'd20, 5'd0, 5'd15, 5'd8));
        issue(rtype_word(SRL, 5'd21, 5'd0, 5'd15, 5'd12));
        issue(rtype_word(SLL, 5'd22, 5'd0, 5'd13, 5'd4));
        drain();
        end_test("immediate");
    endtask

    task automatic memory_test();
        start_test();
        issue(itype_word(ADDI, 5'd23, 5'd0, 16'h0040));
        issue(itype_word(SW, 5'd15, 5'd23, 16'd0));
        issue(itype_word(SW, 5'd11, 5'd23, 16'd4));
        issue(itype_word(SW, 5'd1, 5'd23, 16'hfffc));
        issue(itype_word(SH, 5'd13, 5'd23, 16'd8));
        issue(itype_word(SH, 5'd15, 5'd23, 16'd10));
        issue(itype_word(SB, 5'd15, 5'd23, 16'd13));
        issue(itype_word(SB, 5'd14, 5'd23, 16'd14));
        issue(itype_word(LW, 5'd24, 5'd23, 16'd0));
        issue(itype_word(LH, 5'd25, 5'd23, 16'd2));
        issue(itype_word(LHU, 5'd26, 5'd23, 16'd2));
        issue(itype_word(LB, 5'd27, 5'd23, 16'd1));
        issue(itype_word(LBU, 5'd28, 5'd23, 16'd3));
        issue(itype_word(LW, 5'd29, 5'd23, 16'd8));
        issue(itype_word(LW, 5'd30, 5'd23, 16'd12));
        issue(itype_word(LB, 5'd31, 5'd23, 16'd13));
        issue(itype_word(LHU, 5'd24, 5'd23, 16'd10));
        issue(itype_word(LW, 5'd25, 5'd23, 16'd4));
        issue(itype_word(LW, 5'd27, 5'd23, 16'hfffc));
        // loaded values used two and three slots later
        issue(32'h0000_0000);
        issue(rtype_word(ADDU, 5'd26, 5'd27, 5'd25, 5'd0));
        drain();
        end_test("memory");
    endtask

    task automatic halt_test();
        start_test();
        issue(itype_word(ADDI, 5'd1, 5'd0, 16'd100));
        issue(itype_word(ADDI, 5'd2, 5'd1, 16'd1));
        issue(rtype_word(ADDU, 5'd3, 5'd2, 5'd1, 5'd0));
        hold_pipeline(5);
        issue(rtype_word(ADDU, 5'd4, 5'd3, 5'd2, 5'd0));
        issue(rtype_word(SUBU, 5'd5, 5'd4, 5'd1, 5'd0));
        issue(itype_word(SW, 5'd5, 5'd23, 16'd32));
        hold_pipeline(2);
        issue(itype_word(LW, 5'd6, 5'd23, 16'd32));
        issue(32'h0000_0000);
        issue(rtype_word(ADDU, 5'd7, 5'd6, 5'd6, 5'd0));
        drain();
        end_test("halt");
    endtask

    task automatic random_test();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] word;
        logic [5:0]  fn;
        logic [5:0]  op;
        int          sel;
        start_test();
        for (int k = 0; k < 50; k++) begin
            r1  = $random(seed);
            r2  = $random(seed);
            sel = r1 % 16;
            if (sel < 10) begin
                case (sel)
                    0:       fn = ADDU;
                    1:       fn = SUBU;
                    2:       fn = AND;
                    3:       fn = OR;
                    4:       fn = XOR;
                    5:       fn = NOR;
                    6:       fn = SLT;
                    7:       fn = SLL;
                    8:       fn = SRL;
                    default: fn = SRA;
                endcase
                word = rtype_word(fn, r2[4:0], r2[9:5], r2[14:10], r2[19:15]);
            end else begin
                case (sel)
                    10:      op = ADDI;
                    11:      op = SLTI;
                    12:      op = ANDI;
                    13:      op = ORI;
                    14:      op = XORI;
                    default: op = LUI;
                endcase
                word = itype_word(op, r2[4:0], r2[9:5], r2[31:16]);
            end
            issue(word);
        end
        drain();
        end_test("random");
    endtask

    // write-back monitor, one event per non-halted cycle with o_wb_valid
    always @(posedge i_clk) begin
        if (!i_reset && prev_halt) begin
            assert (o_wb_valid == prev_valid && o_wb_reg == prev_reg && o_wb_data == prev_data)
            else begin
                $display("write-back outputs changed at %0t while the pipeline was halted", $time);
                errors++;
            end
        end
        if (!i_reset && !i_halt && o_wb_valid) begin
            checks++;
            assert (exp_reg.size() > 0) else begin
                $display("unexpected write-back to r%0d at %0t", o_wb_reg, $time);
                errors++;
            end
            if (exp_reg.size() > 0) begin
                want_reg  = exp_reg.pop_front();
                want_data = exp_data.pop_front();
                assert (o_wb_reg == want_reg) else begin
                    $display("[FAIL] %0t o_wb_reg expected %0d got %0d",
                             $time, want_reg, o_wb_reg);
                    errors++;
                end
                assert (o_wb_data == want_data) else begin
                    $display("[FAIL] %0t o_wb_data expected %h got %h",
                             $time, want_data, o_wb_data);
                    errors++;
                end
            end
        end
        prev_halt  = i_halt;
        prev_valid = o_wb_valid;
        prev_reg   = o_wb_reg;
        prev_data  = o_wb_data;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, tests did not complete", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        i_reset     = 1'b1;
        i_halt      = 1'b0;
        i_instr     = '0;
        prev_halt   = 1'b0;
        prev_valid  = 1'b0;
        prev_reg    = '0;
        prev_data   = '0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        cycle_count = 0;
        seed        = 73;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_model[i] = '0;
        end
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;

        nop_test();
        dependency_test();
        immediate_test();
        memory_test();
        halt_test();
        random_test();

        $display("%0d tests, %0d write-back checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- exec_pipeline.f
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/alu.sv
hw/forward_unit.sv
hw/instruction_decode.sv
hw/instruction_exec.sv
hw/mem_writeback.sv
hw/exec_pipeline.sv
bench/exec_pipeline_sva.sv
bench/exec_pipeline_tb.sv
